// File: rtl/clk_div_config.svh
`ifndef CLK_DIV_CONFIG_SVH
`define CLK_DIV_CONFIG_SVH

// width of the divide count, the counter and last_transition
`define CLK_DIV_COUNTER_BITS 16

// flops per synchronizer chain, both directions
// the chain shift code assumes 2 or more
`define CLK_DIV_SYNC_STAGES 2

`endif

// File: rtl/clk_div_pkg.sv
`include "clk_div_config.svh"

package clk_div_pkg;

   // command opcodes on the axi side port
   typedef enum logic [1:0] {
      OP_NOP        = 2'd0,   // no effect
      OP_SET_CYCLES = 2'd1,   // cmd_data -> divide count
      OP_RUN        = 2'd2,   // start dividing
      OP_STOP       = 2'd3    // back to bypass
   } div_op_e;

   // core mode
   typedef enum logic {
      ST_BYPASS = 1'b0,       // output_clk = master_clk
      ST_RUN    = 1'b1        // output_clk = divided clock
   } div_state_e;

   // one full configuration, moved as a unit across the crossing
   typedef struct packed {
      logic                             run;
      logic [`CLK_DIV_COUNTER_BITS-1:0] cycles;
   } div_cfg_t;

endpackage

// File: rtl/div_cmd_regs.sv
`include "clk_div_config.svh"

module div_cmd_regs import clk_div_pkg::*; (
   input  logic                             axi_clk,
   input  logic                             axi_resetn,
   input  logic                             cmd_strobe,
   input  div_op_e                          cmd_op,
   input  logic [`CLK_DIV_COUNTER_BITS-1:0] cmd_data,
   output div_cfg_t                         cfg,
   output logic                             cfg_update
);

   div_cfg_t cfg_next;      // live config after this cycle's command
   logic     cfg_changed;   // command actually alters the stored value

   // opcode decode
   // without a strobe the inputs are ignored entirely
   always_comb begin
      cfg_next = cfg;
      if (cmd_strobe) begin
         case (cmd_op)
            OP_SET_CYCLES: begin
               cfg_next.cycles = cmd_data;   // run bit untouched
            end
            OP_RUN: begin
               cfg_next.run = 1'b1;
            end
            OP_STOP: begin
               cfg_next.run = 1'b0;          // count is kept for the next run
            end
            default: begin
               cfg_next = cfg;               // OP_NOP
            end
         endcase
      end
   end

   // redundant writes and nops stay off the crossing
   assign cfg_changed = (cfg_next != cfg);

   // cfg and cfg_update move on the same edge, one cycle after the strobe
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         cfg        <= '0;             // stopped, count 0
         cfg_update <= 1'b0;
      end else begin
         cfg        <= cfg_next;
         cfg_update <= cfg_changed;    // single cycle pulse per real change
      end
   end

endmodule

// File: rtl/div_cfg_crossing.sv
`include "clk_div_config.svh"

module div_cfg_crossing import clk_div_pkg::*; (
   input  logic     axi_clk,
   input  logic     axi_resetn,
   input  logic     master_clk,
   input  logic     divider_rstn,
   input  div_cfg_t cfg,          // live config, axi_clk domain
   input  logic     cfg_update,   // cfg just changed
   output div_cfg_t cfg_sync      // config in master_clk domain
);

   // axi_clk side
   div_cfg_t                        snapshot;    // config in flight
   logic                            req_tgl;     // flips once per transfer
   logic                            pending;     // update seen while busy
   logic [`CLK_DIV_SYNC_STAGES-1:0] ack_sync;    // ack_tgl into axi_clk
   logic                            xfer_busy;   // request not yet acknowledged
   logic                            launch;      // start a transfer this cycle

   // master_clk side
   logic [`CLK_DIV_SYNC_STAGES-1:0] req_sync;    // req_tgl into master_clk
   logic                            ack_tgl;     // last request level taken
   logic                            req_change;  // new request arrived

   // request and ack levels differ for the whole round trip
   assign xfer_busy = (req_tgl != ack_sync[`CLK_DIV_SYNC_STAGES-1]);

   // a pending update goes out as soon as the ack is back
   assign launch = !xfer_busy && (cfg_update || pending);

   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         req_tgl  <= 1'b0;
         pending  <= 1'b0;
         ack_sync <= '0;
      end else begin
         ack_sync <= {ack_sync[`CLK_DIV_SYNC_STAGES-2:0], ack_tgl};
         if (launch) begin
            req_tgl <= ~req_tgl;
            pending <= 1'b0;      // the live cfg already holds the latest value
         end else if (cfg_update) begin
            pending <= 1'b1;      // absorbed, crosses after this transfer
         end
      end
   end

   // snapshot only loads on launch, so it is frozen while busy
   always_ff @(posedge axi_clk) begin
      if (launch) begin
         snapshot <= cfg;         // fresh copy of the live cfg
      end
   end

   // a level change on the synchronized request marks new data
   assign req_change = (req_sync[`CLK_DIV_SYNC_STAGES-1] != ack_tgl);

   // master side
   // snapshot has been stable for the full synchronizer delay when req_change fires
   always_ff @(posedge master_clk or negedge divider_rstn) begin
      if (!divider_rstn) begin
         req_sync <= '0;
         ack_tgl  <= 1'b0;
         cfg_sync <= '0;          // run = 0, core starts in bypass
      end else begin
         req_sync <= {req_sync[`CLK_DIV_SYNC_STAGES-2:0], req_tgl};
         if (req_change) begin
            cfg_sync <= snapshot;
            ack_tgl  <= req_sync[`CLK_DIV_SYNC_STAGES-1];   // echo back the level
         end
      end
   end

endmodule

// File: rtl/clk_div_core.sv
`include "clk_div_config.svh"

module clk_div_core import clk_div_pkg::*; (
   input  logic     master_clk,
   input  logic     divider_rstn,
   input  div_cfg_t cfg_sync,
   output logic     output_clk
);

   div_state_e                       state;
   logic [`CLK_DIV_COUNTER_BITS-1:0] counter;           // free count while running
   logic [`CLK_DIV_COUNTER_BITS-1:0] last_transition;   // counter at last toggle
   logic [`CLK_DIV_COUNTER_BITS-1:0] elapsed;           // cycles since last toggle
   logic                             divided_clk;
   logic                             toggle_due;

   // modulo subtraction, counter wrap does not disturb the spacing
   assign elapsed = counter - last_transition;

   // count 0 and count 1 both toggle on every cycle
   assign toggle_due = (elapsed >= cfg_sync.cycles);

   always_ff @(posedge master_clk or negedge divider_rstn) begin
      if (!divider_rstn) begin
         state           <= ST_BYPASS;
         counter         <= '0;
         last_transition <= '0;
         divided_clk     <= 1'b0;
      end else begin
         case (state)
            ST_BYPASS: begin
               counter         <= '0;   // held so a run starts clean
               last_transition <= '0;
               divided_clk     <= 1'b0;
               if (cfg_sync.run) begin
                  state <= ST_RUN;
               end
            end
            ST_RUN: begin
               if (!cfg_sync.run) begin
                  state           <= ST_BYPASS;
                  counter         <= '0;
                  last_transition <= '0;
                  divided_clk     <= 1'b0;   // low on entry to bypass
               end else begin
                  counter <= counter + 1'b1;
                  // a new count applies to the half period in progress
                  if (toggle_due) begin
                     divided_clk     <= ~divided_clk;
                     last_transition <= counter;
                  end
               end
            end
         endcase
      end
   end

   // plain clock mux, not glitch free on mode change
   always_comb begin
      output_clk = master_clk;           // bypass, also during reset
      if (state == ST_RUN) begin
         output_clk = divided_clk;
      end
   end

endmodule

// File: rtl/clk_div_top.sv
`include "clk_div_config.svh"

module clk_div_top import clk_div_pkg::*; (
   input  logic                             master_clk,
   input  logic                             axi_clk,
   input  logic                             divider_rstn,   // master_clk side
   input  logic                             axi_resetn,     // axi_clk side
   input  logic                             cmd_strobe,
   input  div_op_e                          cmd_op,
   input  logic [`CLK_DIV_COUNTER_BITS-1:0] cmd_data,
   output logic                             output_clk
);

   div_cfg_t cfg;          // live config, axi_clk
   logic     cfg_update;   // one cycle pulse on change
   div_cfg_t cfg_sync;     // config seen by the core, master_clk

   // command register
   div_cmd_regs u_cmd_regs (
      .axi_clk    (axi_clk),
      .axi_resetn (axi_resetn),
      .cmd_strobe (cmd_strobe),
      .cmd_op     (cmd_op),
      .cmd_data   (cmd_data),
      .cfg        (cfg),
      .cfg_update (cfg_update)
   );

   // axi_clk to master_clk transfer
   div_cfg_crossing u_cfg_crossing (
      .axi_clk      (axi_clk),
      .axi_resetn   (axi_resetn),
      .master_clk   (master_clk),
      .divider_rstn (divider_rstn),
      .cfg          (cfg),
      .cfg_update   (cfg_update),
      .cfg_sync     (cfg_sync)
   );

   // divider and output mux
   clk_div_core u_core (
      .master_clk   (master_clk),
      .divider_rstn (divider_rstn),
      .cfg_sync     (cfg_sync),
      .output_clk   (output_clk)
   );

endmodule

// File: bench/clk_div_assertions.sv
`include "clk_div_config.svh"

module clk_div_assertions import clk_div_pkg::*; (
   input logic       clk,
   input logic       rstn,
   input logic       busy,          // transfer in flight, crossing side only
   input div_cfg_t   held_cfg,      // must not move while busy
   input div_state_e state,         // core mode, tied to ST_RUN on the crossing
   input logic       divided_clk    // tied low on the crossing
);
   timeunit 1ns;
   timeprecision 1ps;

   // a round trip is two synchronizer chains plus edge detect, with margin
   localparam int ROUND_TRIP_LIMIT = 4 * (`CLK_DIV_SYNC_STAGES + 2);

   logic [7:0] busy_cycles;   // length of the current transfer in clk cycles

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         busy_cycles <= '0;
      end else if (busy) begin
         busy_cycles <= 8'(busy_cycles + 8'd1);
      end else begin
         busy_cycles <= '0;
      end
   end

   // snapshot frozen for the whole transfer
   snapshot_stable: assert property (@(posedge clk) disable iff (!rstn)
      busy |=> $stable(held_cfg))
      else $error("snapshot changed while a transfer was in flight");

   // acknowledge must come back
   ack_returns: assert property (@(posedge clk) disable iff (!rstn)
      busy_cycles <= ROUND_TRIP_LIMIT)
      else $error("acknowledge toggle did not return in time");

   // divided clock parked low in bypass
   bypass_low: assert property (@(posedge clk) disable iff (!rstn)
      (state == ST_BYPASS) |-> !divided_clk)
      else $error("divided clock is high in bypass state");

endmodule

bind div_cfg_crossing clk_div_assertions u_xfer_checks (
   .clk         (axi_clk),
   .rstn        (axi_resetn),
   .busy        (xfer_busy),
   .held_cfg    (snapshot),
   .state       (ST_RUN),
   .divided_clk (1'b0)
);

bind clk_div_core clk_div_assertions u_core_checks (
   .clk         (master_clk),
   .rstn        (divider_rstn),
   .busy        (1'b0),
   .held_cfg    (cfg_sync),
   .state       (state),
   .divided_clk (divided_clk)
);

// File: bench/tb_clk_div.sv
`include "clk_div_config.svh"

module tb_clk_div import clk_div_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int SEED           = 32409;
   localparam int NUM_SEQ        = 40;
   localparam int CYCLES_PER_SEQ = 150;                      // worst case per sequence
   localparam int TIMEOUT_CYCLES = NUM_SEQ * CYCLES_PER_SEQ; // master_clk cycles
   localparam int SETTLE         = 20;    // command in effect after this
   localparam int MAX_CYCLES     = 20;
   localparam int MASTER_HALF    = 50;    // 100 ns period
   localparam int AXI_HALF       = 65;    // 130 ns period
   localparam int DRIVE_DELAY    = 5;
   localparam int SAMPLE_DELAY   = 10;    // output settled after the edge

   logic                             master_clk;
   logic                             axi_clk;
   logic                             divider_rstn;
   logic                             axi_resetn;
   logic                             cmd_strobe;
   div_op_e                          cmd_op;
   logic [`CLK_DIV_COUNTER_BITS-1:0] cmd_data;
   logic                             output_clk;

   logic model_run;      // reference copy of the run bit
   int   model_cycles;   // reference copy of the divide count

   clk_div_top u_clk_div_top (
      .master_clk   (master_clk),
      .axi_clk      (axi_clk),
      .divider_rstn (divider_rstn),
      .axi_resetn   (axi_resetn),
      .cmd_strobe   (cmd_strobe),
      .cmd_op       (cmd_op),
      .cmd_data     (cmd_data),
      .output_clk   (output_clk)
   );

   initial begin
      master_clk = 1'b0;
      forever #MASTER_HALF master_clk = ~master_clk;
   end

   initial begin
      axi_clk = 1'b0;
      forever #AXI_HALF axi_clk = ~axi_clk;   // unrelated to master_clk
   end

   // watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge master_clk);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout after %0d master_clk cycles, run did not complete", TIMEOUT_CYCLES);
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   // one strobe cycle on the axi side, then back to idle
   task automatic send_cmd(input div_op_e op, input logic [`CLK_DIV_COUNTER_BITS-1:0] data);
      @(posedge axi_clk);
      #DRIVE_DELAY;
      cmd_strobe = 1'b1;
      cmd_op     = op;
      cmd_data   = data;
      @(posedge axi_clk);
      #DRIVE_DELAY;
      cmd_strobe = 1'b0;
      cmd_op     = OP_NOP;
   endtask

   // bypass: output_clk high after each rise, low after each fall
   task automatic check_bypass(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge master_clk);
         #SAMPLE_DELAY;
         assert (output_clk === 1'b1) else
            abort_run($sformatf("ERR output_clk expected 'h1 measured 'h%0h after rise",
                                output_clk));
         @(negedge master_clk);
         #SAMPLE_DELAY;
         assert (output_clk === 1'b0) else
            abort_run($sformatf("ERR output_clk expected 'h0 measured 'h%0h after fall",
                                output_clk));
      end
   endtask

   // spacing of output_clk transitions in master_clk cycles
   task automatic check_spacing(input int expected);
      int   transitions;
      int   since_last;
      logic prev;
      transitions = 0;
      since_last  = 0;
      @(posedge master_clk);
      #SAMPLE_DELAY;
      prev = output_clk;
      while (transitions < 5) begin
         @(posedge master_clk);
         #SAMPLE_DELAY;
         since_last++;
         if (output_clk !== prev) begin
            transitions++;
            if (transitions > 2) begin   // first two may hold an old half period
               assert (since_last == expected) else
                  abort_run($sformatf("ERR output_clk spacing expected 'h%0h measured 'h%0h",
                                      expected, since_last));
            end
            since_last = 0;
            prev       = output_clk;
         end
      end
   endtask

   initial begin
      int      seq;
      int      cycles;
      div_op_e op;
      cmd_strobe   = 1'b0;
      cmd_op       = OP_NOP;
      cmd_data     = '0;
      divider_rstn = 1'b0;
      axi_resetn   = 1'b0;
      model_run    = 1'b0;
      model_cycles = 0;
      void'($urandom(SEED));

      repeat (8) @(posedge master_clk);
      #DRIVE_DELAY;
      divider_rstn = 1'b1;   // both released together
      axi_resetn   = 1'b1;
      check_bypass(4);       // stopped after reset

      for (seq = 0; seq < NUM_SEQ; seq++) begin
         if (seq < 2) begin
            cycles = seq;    // counts 0 and 1 first, both one cycle apart
            op     = OP_RUN;
         end else begin
            cycles = $urandom_range(0, MAX_CYCLES);
            case ($urandom_range(0, 2))
               0:       op = OP_RUN;
               1:       op = OP_STOP;
               default: op = OP_NOP;
            endcase
         end
         // decoy count right before the real one, lands on the pending path
         if ($urandom_range(0, 3) == 0) begin
            send_cmd(OP_SET_CYCLES, 16'($urandom_range(0, MAX_CYCLES)));
         end
         send_cmd(OP_SET_CYCLES, 16'(cycles));
         model_cycles = cycles;
         send_cmd(op, '0);
         case (op)
            OP_RUN:  model_run = 1'b1;
            OP_STOP: model_run = 1'b0;
            default: ;                    // nop keeps the mode
         endcase

         repeat (SETTLE) @(posedge master_clk);
         if (model_run) begin
            check_spacing((model_cycles < 1) ? 1 : model_cycles);
         end else begin
            check_bypass(4);
         end
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+rtl
rtl/clk_div_pkg.sv
rtl/div_cmd_regs.sv
rtl/div_cfg_crossing.sv
rtl/clk_div_core.sv
rtl/clk_div_top.sv
bench/clk_div_assertions.sv
bench/tb_clk_div.sv

// File: Makefile
VERILATOR = verilator
TOP       = tb_clk_div
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
            --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: sim clean

# build, then run; a $fatal in the bench gives a failing exit status
sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
